/* sources.f */
src/mdio_pkg.sv
src/phy_reset_seq.sv
src/mdio_cmd_stage.sv
src/mdio_frame_shifter.sv
src/mdio_read_capture.sv
src/mdio_mgmt_top.sv
dv/mdio_mgmt_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the MDIO management testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module mdio_mgmt_tb -o mdio_mgmt_sim

sim_out=$(./obj_dir/mdio_mgmt_sim)
echo "$sim_out"

if grep -qx "NO ERRORS" <<< "$sim_out"; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* dv/mdio_mgmt_tb.sv */
// ********************
// MDIO management testbench
// PHY register model on the MDIO pins and a table of MDIO operations
// ********************

`timescale 1ns/1ps

module mdio_mgmt_tb;

  localparam logic [4:0] PHY_ADDR       = 5'd6;
  localparam int         WAKE_CYCLES    = 32;
  localparam int         NUM_ROWS       = 8;
  localparam int         TIMEOUT_CYCLES = NUM_ROWS * 70 + 400;

  typedef struct packed {
    logic        wr;
    logic [4:0]  addr;
    logic [15:0] wdata;
    logic [15:0] exp;
    logic        wait_done;
  } row_t;

  logic        eth_mdc = 1'b0;
  logic        rst_i;
  logic        req_i;
  logic        req_write_i;
  logic [4:0]  req_reg_i;
  logic [15:0] req_wdata_i;
  logic        busy_o;
  logic [15:0] rd_data_o;
  logic        done_o;
  logic        pll_locked_i;
  logic        eth_mdio_i;
  logic        eth_mdio_o;
  logic        eth_mdio_oe_o;
  logic        eth_phy_resetn_o;

  row_t        stim [NUM_ROWS];
  int          accept_cyc [NUM_ROWS];
  logic [15:0] phy_regs [32];
  logic [15:0] shadow_regs [32];
  logic [31:0] rng;
  int          cycle = 0;
  int          err_cnt = 0;
  int          done_cnt = 0;
  int          last_start = 0;

  // PHY model state
  logic [63:0] mdio_frame;
  logic [6:0]  mdio_pos = '0;
  logic [5:0]  bit_sel;
  logic        phy_bit;
  int          oe_bits;
  int          frame_start;
  int          frames_seen = 0;
  logic [63:0] frame_q [$];
  int          oe_q [$];
  int          start_q [$];

  mdio_mgmt_top #(
    .PHY_ADDR        (PHY_ADDR),
    .PHY_WAKE_CYCLES (WAKE_CYCLES)
  ) mdio_mgmt_top_inst (
    .eth_mdc          (eth_mdc),
    .rst_i            (rst_i),
    .req_i            (req_i),
    .req_write_i      (req_write_i),
    .req_reg_i        (req_reg_i),
    .req_wdata_i      (req_wdata_i),
    .busy_o           (busy_o),
    .rd_data_o        (rd_data_o),
    .done_o           (done_o),
    .pll_locked_i     (pll_locked_i),
    .eth_mdio_i       (eth_mdio_i),
    .eth_mdio_o       (eth_mdio_o),
    .eth_mdio_oe_o    (eth_mdio_oe_o),
    .eth_phy_resetn_o (eth_phy_resetn_o)
  );

  always #10 eth_mdc = ~eth_mdc;

  always @(posedge eth_mdc) begin
    cycle <= cycle + 1;
  end

  initial begin
    wait (cycle >= TIMEOUT_CYCLES);
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (actual !== expected) begin
      $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
      err_cnt++;
    end
  endtask

  task automatic check_within(input string what, input int cycles, input int limit);
    if (cycles > limit) begin
      $display("%s took %0d cycles, more than %0d", what, cycles, limit);
      err_cnt++;
    end
  endtask

  task automatic set_row(input int i, input logic wr, input logic [4:0] addr,
                         input logic wait_done);
    stim[i].wr        = wr;
    stim[i].addr      = addr;
    stim[i].wait_done = wait_done;
  endtask

  // ********************
  // stimulus table
  // ********************

  // wait_done low means strobed while the previous frame shifts
  task automatic build_table();
    rng = 32'd11;
    for (int r = 0; r < 32; r++) begin
      rng = xorshift32(rng);
      phy_regs[r]    = rng[15:0];
      shadow_regs[r] = rng[15:0];
    end
    set_row(0, 1'b1, 5'd3,  1'b1);
    set_row(1, 1'b0, 5'd3,  1'b1);
    set_row(2, 1'b0, 5'd7,  1'b1);
    set_row(3, 1'b1, 5'd18, 1'b1);
    set_row(4, 1'b1, 5'd9,  1'b0);
    set_row(5, 1'b0, 5'd18, 1'b0);
    set_row(6, 1'b0, 5'd9,  1'b1);
    set_row(7, 1'b0, 5'd31, 1'b1);
    // expected reads follow the most recent write, else the seed
    for (int i = 0; i < NUM_ROWS; i++) begin
      stim[i].wdata = '0;
      stim[i].exp   = '0;
      if (stim[i].wr) begin
        rng = xorshift32(rng);
        stim[i].wdata = rng[15:0];
        shadow_regs[stim[i].addr] = rng[15:0];
      end else begin
        stim[i].exp = shadow_regs[stim[i].addr];
      end
    end
  endtask

  task automatic issue_row(input int i);
    if (stim[i].wait_done) begin
      wait (done_cnt == i);
    end else begin
      repeat (10) @(negedge eth_mdc);
    end
    @(negedge eth_mdc);
    while (busy_o) @(negedge eth_mdc);
    req_i         = 1'b1;
    req_write_i   = stim[i].wr;
    req_reg_i     = stim[i].addr;
    req_wdata_i   = stim[i].wdata;
    accept_cyc[i] = cycle + 1;
    @(negedge eth_mdc);
    req_i = 1'b0;
    compare_value($sformatf("row %0d busy after accept", i), 1, 64'(busy_o));
    if (!stim[i].wait_done) begin
      repeat (20) begin
        @(negedge eth_mdc);
        compare_value($sformatf("row %0d busy while held", i), 1, 64'(busy_o));
      end
    end
  endtask

  task automatic check_completion(input int i);
    logic [63:0] got;
    logic [63:0] want;
    int          oe_cnt;
    int          start;
    if (frame_q.size() == 0) begin
      $display("done pulse for row %0d came without a decoded MDIO frame", i);
      err_cnt++;
      return;
    end
    got    = frame_q.pop_front();
    oe_cnt = oe_q.pop_front();
    start  = start_q.pop_front();
    want   = {32'hFFFF_FFFF, 2'b01, (stim[i].wr ? 2'b01 : 2'b10), PHY_ADDR, stim[i].addr,
              2'b10, stim[i].wdata};
    if (stim[i].wr) begin
      compare_value($sformatf("row %0d write frame", i), want, got);
      compare_value($sformatf("row %0d write oe bits", i), 64, 64'(oe_cnt));
    end else begin
      // turnaround and data of a read belong to the PHY
      compare_value($sformatf("row %0d read header", i), 64'(want[63:18]), 64'(got[63:18]));
      compare_value($sformatf("row %0d read oe bits", i), 46, 64'(oe_cnt));
      compare_value($sformatf("row %0d read data", i), 64'(stim[i].exp), 64'(rd_data_o));
    end
    if (stim[i].wait_done) begin
      compare_value($sformatf("row %0d done latency", i), 66, 64'(cycle - accept_cyc[i]));
    end else begin
      compare_value($sformatf("row %0d frame start", i), 64'(last_start + 64), 64'(start));
    end
    last_start = start;
  endtask

  // ********************
  // PHY register model
  // ********************

  always @(negedge eth_mdc) begin
    if (rst_i || (mdio_pos == 7'd0 && !eth_mdio_oe_o)) begin
      eth_mdio_i = 1'b1;
      mdio_pos   = '0;
    end else begin
      if (mdio_pos == 7'd0) begin
        mdio_frame  = '0;
        oe_bits     = 0;
        frame_start = cycle;
      end
      bit_sel = ~mdio_pos[5:0];
      phy_bit = 1'b1;
      // read data, bit 15 at index 48
      if (mdio_frame[29:28] == 2'b10 && mdio_pos >= 48) begin
        phy_bit = phy_regs[mdio_frame[22:18]][bit_sel[3:0]];
      end
      eth_mdio_i = phy_bit;
      if (eth_mdio_oe_o) begin
        oe_bits++;
        mdio_frame[bit_sel] = eth_mdio_o;
      end else begin
        mdio_frame[bit_sel] = phy_bit;
      end
      mdio_pos = mdio_pos + 7'd1;
      if (mdio_pos == 7'd64) begin
        if (mdio_frame[29:28] == 2'b01 && mdio_frame[27:23] == PHY_ADDR) begin
          phy_regs[mdio_frame[22:18]] = mdio_frame[15:0];
        end
        frame_q.push_back(mdio_frame);
        oe_q.push_back(oe_bits);
        start_q.push_back(frame_start);
        frames_seen++;
        mdio_pos = '0;
      end
    end
  end

  // completion monitor
  always @(negedge eth_mdc) begin
    if (!rst_i && done_o) begin
      if (done_cnt < NUM_ROWS) begin
        check_completion(done_cnt);
      end else begin
        $display("done pulse with no request outstanding");
        err_cnt++;
      end
      done_cnt++;
    end
  end

  initial begin
    int t_mark;
    rst_i        = 1'b1;
    req_i        = 1'b0;
    req_write_i  = 1'b0;
    req_reg_i    = '0;
    req_wdata_i  = '0;
    pll_locked_i = 1'b0;
    eth_mdio_i   = 1'b1;
    build_table();
    repeat (10) @(negedge eth_mdc);
    rst_i = 1'b0;

    // PLL unlocked, a strobe must be ignored
    for (int k = 0; k < 40; k++) begin
      @(negedge eth_mdc);
      compare_value("resetn while unlocked", 0, 64'(eth_phy_resetn_o));
      compare_value("busy while unlocked", 1, 64'(busy_o));
      req_i       = (k == 8);
      req_write_i = 1'b1;
      req_reg_i   = 5'd2;
    end
    compare_value("mdio bits before lock", 0, 64'(mdio_pos));

    @(negedge eth_mdc);
    pll_locked_i = 1'b1;
    t_mark = cycle;
    while (!eth_phy_resetn_o) @(negedge eth_mdc);
    check_within("resetn release after lock", cycle - t_mark, 16);
    t_mark = cycle;
    while (busy_o) @(negedge eth_mdc);
    compare_value("wake delay", 64'(WAKE_CYCLES), 64'(cycle - t_mark));

    for (int i = 0; i < NUM_ROWS; i++) begin
      issue_row(i);
    end
    wait (done_cnt == NUM_ROWS);

    // lock loss at the next sample point
    @(negedge eth_mdc);
    pll_locked_i = 1'b0;
    t_mark = cycle;
    @(negedge eth_mdc);
    while (eth_phy_resetn_o) begin
      compare_value("busy before lock sample", 0, 64'(busy_o));
      @(negedge eth_mdc);
    end
    compare_value("busy at lock loss", 1, 64'(busy_o));
    check_within("resetn drop after lock loss", cycle - t_mark, 16);

    repeat (4) @(negedge eth_mdc);
    // one frame per row, none from the strobe while unlocked
    compare_value("frames decoded", NUM_ROWS, 64'(frames_seen));
    $display("run complete, %0d errors", err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* src/mdio_mgmt_top.sv */
// ********************
// PHY management top level
// reset sequencer plus clause-22 MDIO pipeline
// ********************

`timescale 1ns/1ps

module mdio_mgmt_top #(
  parameter mdio_pkg::mdio_phy_addr_t PHY_ADDR        = 5'd1,
  parameter int                       PHY_WAKE_CYCLES = 32
) (
  input  logic                     eth_mdc,
  input  logic                     rst_i,
  input  logic                     req_i,
  input  logic                     req_write_i,
  input  mdio_pkg::mdio_reg_addr_t req_reg_i,
  input  mdio_pkg::mdio_data_t     req_wdata_i,
  output logic                     busy_o,
  output mdio_pkg::mdio_data_t     rd_data_o,
  output logic                     done_o,
  input  logic                     pll_locked_i,
  input  logic                     eth_mdio_i,
  output logic                     eth_mdio_o,
  output logic                     eth_mdio_oe_o,
  output logic                     eth_phy_resetn_o
);

  import mdio_pkg::*;

  logic          phy_ready;
  logic          frame_load;
  logic          frame_is_read;
  mdio_frame_t   frame_word;
  logic          shifter_idle;
  logic          bit_strobe;
  logic          frame_read;
  logic          frame_end;
  mdio_bit_idx_t bit_idx;

  phy_reset_seq #(
    .PHY_WAKE_CYCLES (PHY_WAKE_CYCLES)
  ) phy_reset_seq_inst (
    .eth_mdc      (eth_mdc),
    .rst_i        (rst_i),
    .pll_locked_i (pll_locked_i),
    .phy_resetn_o (eth_phy_resetn_o),
    .phy_ready_o  (phy_ready)
  );

  mdio_cmd_stage #(
    .PHY_ADDR (PHY_ADDR)
  ) mdio_cmd_stage_inst (
    .eth_mdc         (eth_mdc),
    .rst_i           (rst_i),
    .req_i           (req_i),
    .req_write_i     (req_write_i),
    .req_reg_i       (req_reg_i),
    .req_wdata_i     (req_wdata_i),
    .phy_ready_i     (phy_ready),
    .shifter_idle_i  (shifter_idle),
    .busy_o          (busy_o),
    .frame_load_o    (frame_load),
    .frame_is_read_o (frame_is_read),
    .frame_word_o    (frame_word)
  );

  mdio_frame_shifter mdio_frame_shifter_inst (
    .eth_mdc         (eth_mdc),
    .rst_i           (rst_i),
    .frame_load_i    (frame_load),
    .frame_is_read_i (frame_is_read),
    .frame_word_i    (frame_word),
    .shifter_idle_o  (shifter_idle),
    .mdio_o          (eth_mdio_o),
    .mdio_oe_o       (eth_mdio_oe_o),
    .bit_strobe_o    (bit_strobe),
    .frame_read_o    (frame_read),
    .frame_end_o     (frame_end),
    .bit_idx_o       (bit_idx)
  );

  mdio_read_capture mdio_read_capture_inst (
    .eth_mdc      (eth_mdc),
    .rst_i        (rst_i),
    .mdio_i       (eth_mdio_i),
    .bit_strobe_i (bit_strobe),
    .frame_read_i (frame_read),
    .frame_end_i  (frame_end),
    .bit_idx_i    (bit_idx),
    .rd_data_o    (rd_data_o),
    .done_o       (done_o)
  );

endmodule

/* src/mdio_read_capture.sv */
// ********************
// MDIO read capture
// samples read data bits and reports frame completion
// ********************

`timescale 1ns/1ps

module mdio_read_capture (
  input  logic                    eth_mdc,
  input  logic                    rst_i,
  input  logic                    mdio_i,
  input  logic                    bit_strobe_i,
  input  logic                    frame_read_i,
  input  logic                    frame_end_i,
  input  mdio_pkg::mdio_bit_idx_t bit_idx_i,
  output mdio_pkg::mdio_data_t    rd_data_o,
  output logic                    done_o
);

  import mdio_pkg::*;

  // bit 0 arrives with frame_end, so only the upper bits are stored
  localparam int CAP_W = $bits(mdio_data_t) - 1;

  logic [CAP_W-1:0] shift_q;
  logic             data_bit;
  logic             publish;

  assign data_bit = bit_strobe_i && frame_read_i && (bit_idx_i >= READ_DATA_FIRST);
  assign publish  = frame_end_i && frame_read_i;

  // ********************
  // data path
  // ********************

  always_ff @(posedge eth_mdc) begin
    if (data_bit) begin
      shift_q <= {shift_q[CAP_W-2:0], mdio_i};
    end
  end

  // writes leave the last read word in place
  always_ff @(posedge eth_mdc) begin
    if (publish) begin
      rd_data_o <= {shift_q, mdio_i};
    end
  end

  // ********************
  // completion
  // ********************

  always_ff @(posedge eth_mdc) begin
    if (rst_i) begin
      done_o <= 1'b0;
    end else begin
      done_o <= frame_end_i;
    end
  end

endmodule

/* src/mdio_frame_shifter.sv */
// ********************
// MDIO frame serializer
// shifts the frame MSB first and drives the MDIO output enable
// ********************

`timescale 1ns/1ps

module mdio_frame_shifter (
  input  logic                    eth_mdc,
  input  logic                    rst_i,
  input  logic                    frame_load_i,
  input  logic                    frame_is_read_i,
  input  mdio_pkg::mdio_frame_t   frame_word_i,
  output logic                    shifter_idle_o,
  output logic                    mdio_o,
  output logic                    mdio_oe_o,
  output logic                    bit_strobe_o,
  output logic                    frame_read_o,
  output logic                    frame_end_o,
  output mdio_pkg::mdio_bit_idx_t bit_idx_o
);

  import mdio_pkg::*;

  localparam mdio_bit_idx_t LAST_IDX = mdio_bit_idx_t'(FRAME_BITS - 1);

  shift_state_e  state;
  mdio_frame_t   shift_q;
  mdio_bit_idx_t idx_q;
  mdio_bit_idx_t idx_next;
  logic          read_q;
  logic          oe_q;
  logic          running;
  logic          last_bit;
  logic          start;

  assign running  = (state == SHIFT_RUN);
  assign last_bit = running && (idx_q == LAST_IDX);
  // a new frame may follow bit 63 directly
  assign start    = frame_load_i && (!running || last_bit);
  assign idx_next = idx_q + 1'b1;

  // ********************
  // control
  // ********************

  always_ff @(posedge eth_mdc) begin
    if (rst_i) begin
      state  <= SHIFT_IDLE;
      idx_q  <= '0;
      read_q <= 1'b0;
      oe_q   <= 1'b0;
    end else if (start) begin
      state  <= SHIFT_RUN;
      idx_q  <= '0;
      read_q <= frame_is_read_i;
      oe_q   <= 1'b1;
    end else if (last_bit) begin
      state  <= SHIFT_IDLE;
      idx_q  <= '0;
      read_q <= 1'b0;
      oe_q   <= 1'b0;
    end else if (running) begin
      idx_q <= idx_next;
      // reads hand the bus to the PHY at the turnaround
      oe_q  <= !read_q || (idx_next < READ_OE_BITS);
    end
  end

  // payload shift register
  always_ff @(posedge eth_mdc) begin
    if (start) begin
      shift_q <= frame_word_i;
    end else if (running) begin
      shift_q <= {shift_q[FRAME_BITS-2:0], 1'b0};
    end
  end

  // ********************
  // outputs
  // ********************

  // idle one bit early so a registered load from the command stage
  // lands on the edge right after bit 63
  assign shifter_idle_o = !running || (idx_q >= LAST_IDX - 1'b1);

  assign mdio_o       = running ? shift_q[FRAME_BITS-1] : 1'b1;
  assign mdio_oe_o    = oe_q;
  assign bit_strobe_o = running;
  assign frame_read_o = read_q;
  assign frame_end_o  = last_bit;
  assign bit_idx_o    = idx_q;

  a_read_bus_released : assert property (
    @(posedge eth_mdc) disable iff (rst_i)
    (frame_read_o && (bit_idx_o >= READ_OE_BITS)) |-> !mdio_oe_o
  );

endmodule

/* src/mdio_cmd_stage.sv */
// ********************
// MDIO command stage
// one-entry holding register and frame word assembly
// ********************

`timescale 1ns/1ps

module mdio_cmd_stage #(
  parameter mdio_pkg::mdio_phy_addr_t PHY_ADDR = 5'd1
) (
  input  logic                     eth_mdc,
  input  logic                     rst_i,
  input  logic                     req_i,
  input  logic                     req_write_i,
  input  mdio_pkg::mdio_reg_addr_t req_reg_i,
  input  mdio_pkg::mdio_data_t     req_wdata_i,
  input  logic                     phy_ready_i,
  input  logic                     shifter_idle_i,
  output logic                     busy_o,
  output logic                     frame_load_o,
  output logic                     frame_is_read_o,
  output mdio_pkg::mdio_frame_t    frame_word_o
);

  import mdio_pkg::*;

  logic           hold_valid_q;
  logic           hold_write_q;
  mdio_reg_addr_t hold_reg_q;
  mdio_data_t     hold_wdata_q;
  logic           take;
  logic           launch;
  logic [1:0]     opcode;
  logic [1:0]     turnaround;
  mdio_data_t     data_field;
  mdio_frame_t    word;

  assign busy_o = !phy_ready_i || hold_valid_q;
  assign take   = req_i && !busy_o;
  assign launch = hold_valid_q && shifter_idle_i;

  // ********************
  // frame assembly
  // ********************

  assign opcode     = hold_write_q ? MDIO_OP_WRITE : MDIO_OP_READ;
  // read turnaround is released, bus pulled high
  assign turnaround = hold_write_q ? MDIO_TA_WRITE : 2'b11;
  assign data_field = hold_write_q ? hold_wdata_q : '0;
  assign word = {{PREAMBLE_BITS{1'b1}}, MDIO_START, opcode, PHY_ADDR, hold_reg_q,
                 turnaround, data_field};

  always_ff @(posedge eth_mdc) begin
    if (rst_i) begin
      hold_valid_q <= 1'b0;
      frame_load_o <= 1'b0;
    end else begin
      frame_load_o <= launch;
      if (take) begin
        hold_valid_q <= 1'b1;
      end else if (launch) begin
        hold_valid_q <= 1'b0;
      end
    end
  end

  // pending command and outgoing word
  always_ff @(posedge eth_mdc) begin
    if (take) begin
      hold_write_q <= req_write_i;
      hold_reg_q   <= req_reg_i;
      hold_wdata_q <= req_wdata_i;
    end
    if (launch) begin
      frame_word_o    <= word;
      frame_is_read_o <= !hold_write_q;
    end
  end

  a_load_when_idle : assert property (
    @(posedge eth_mdc) disable iff (rst_i)
    frame_load_o |-> shifter_idle_i
  );

endmodule

/* src/phy_reset_seq.sv */
// ********************
// PHY reset sequencer
// samples PLL lock into the PHY reset, then waits for PHY wake-up
// ********************

`timescale 1ns/1ps

module phy_reset_seq #(
  parameter int PHY_WAKE_CYCLES = 32
) (
  input  logic eth_mdc,
  input  logic rst_i,
  input  logic pll_locked_i,
  output logic phy_resetn_o,
  output logic phy_ready_o
);

  localparam int WAKE_W = $clog2(PHY_WAKE_CYCLES + 1);

  logic [3:0]        sample_cnt;
  logic [WAKE_W-1:0] wake_cnt;
  logic              sample_pt;
  logic              lock_lost;

  // one sample point every 16 cycles
  assign sample_pt = (sample_cnt == 4'h0);
  assign lock_lost = sample_pt && !pll_locked_i;

  always_ff @(posedge eth_mdc) begin
    if (rst_i) begin
      sample_cnt   <= 4'h0;
      phy_resetn_o <= 1'b0;
    end else begin
      sample_cnt <= sample_cnt + 4'd1;
      if (sample_pt) begin
        phy_resetn_o <= pll_locked_i;
      end
    end
  end

  // ********************
  // wake-up delay
  // ********************

  always_ff @(posedge eth_mdc) begin
    if (rst_i) begin
      wake_cnt    <= '0;
      phy_ready_o <= 1'b0;
    end else if (lock_lost) begin
      // drop ready on the same edge that resetn drops
      phy_ready_o <= 1'b0;
      if (!phy_resetn_o) begin
        wake_cnt <= '0;
      end
    end else if (!phy_resetn_o) begin
      wake_cnt <= '0;
    end else if (!phy_ready_o) begin
      wake_cnt <= wake_cnt + 1'b1;
      if (wake_cnt == WAKE_W'(PHY_WAKE_CYCLES - 1)) begin
        phy_ready_o <= 1'b1;
      end
    end
  end

  // the management engine must never talk to a PHY held in reset
  a_ready_needs_resetn : assert property (
    @(posedge eth_mdc) disable iff (rst_i)
    phy_ready_o |-> phy_resetn_o
  );

endmodule

/* src/mdio_pkg.sv */
// ********************
// MDIO management shared definitions
// field widths, clause-22 frame codes, serializer states
// ********************

package mdio_pkg;

  // ********************
  // frame geometry
  // ********************

  localparam int FRAME_BITS      = 64;
  localparam int PREAMBLE_BITS   = 32;
  // MAC drives preamble, start, opcode and both addresses on a read
  localparam int READ_OE_BITS    = 46;
  // data bit 15 of a read
  localparam int READ_DATA_FIRST = 48;

  // ********************
  // field types
  // ********************

  typedef logic [4:0]            mdio_phy_addr_t;
  typedef logic [4:0]            mdio_reg_addr_t;
  typedef logic [15:0]           mdio_data_t;
  typedef logic [FRAME_BITS-1:0] mdio_frame_t;
  typedef logic [5:0]            mdio_bit_idx_t;

  // ********************
  // clause-22 codes
  // ********************

  localparam logic [1:0] MDIO_START    = 2'b01;
  localparam logic [1:0] MDIO_OP_READ  = 2'b10;
  localparam logic [1:0] MDIO_OP_WRITE = 2'b01;
  localparam logic [1:0] MDIO_TA_WRITE = 2'b10;

  // serializer
  typedef enum logic [0:0] {
    SHIFT_IDLE,
    SHIFT_RUN
  } shift_state_e;

endpackage
